/* src/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OP_LOAD = 7'b000_0011;
    localparam logic [6:0] OP_STORE = 7'b010_0011;
    localparam logic [6:0] OP_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OP_OP = 7'b011_0011;
    localparam logic [6:0] OP_LUI = 7'b011_0111;
    localparam logic [6:0] OP_AUIPC = 7'b001_0111;
    localparam logic [6:0] OP_BRANCH = 7'b110_0011;
    localparam logic [6:0] OP_JAL = 7'b110_1111;
    localparam logic [6:0] OP_JALR = 7'b110_0111;

    localparam logic [2:0] F3_BEQ = 3'd0;
    localparam logic [2:0] F3_BNE = 3'd1;
    localparam logic [2:0] F3_BLT = 3'd4;
    localparam logic [2:0] F3_BGE = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    localparam logic [2:0] F3_LW = 3'd2;
    localparam logic [2:0] F3_SW = 3'd2;
    localparam logic [2:0] F3_JALR = 3'd0;

    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL = 3'd1;
    localparam logic [2:0] F3_SLT = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR = 3'd4;
    localparam logic [2:0] F3_SR = 3'd5;   // srl or sra
    localparam logic [2:0] F3_OR = 3'd6;
    localparam logic [2:0] F3_AND = 3'd7;

    localparam logic [6:0] IMM7_ALT = 7'h20;   // sub, sra

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        st_boot, st_run, st_load_wb
    } ctrl_state_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t imm;
        alu_op_e alu_op;
        logic [2:0] funct3;
        logic use_imm;    // alu b from imm
        logic use_pc;     // alu a from pc
        logic wr_rd;
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic illegal;
    } decoded_t;

endpackage

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import rv32i_pkg::*; (
    input wire instr_t instr,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] imm7;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign imm7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: alu_from_f3 = alt ? alu_sub : alu_add;
            F3_SLL: alu_from_f3 = alu_sll;
            F3_SLT: alu_from_f3 = alu_slt;
            F3_SLTU: alu_from_f3 = alu_sltu;
            F3_XOR: alu_from_f3 = alu_xor;
            F3_SR: alu_from_f3 = alt ? alu_sra : alu_srl;
            F3_OR: alu_from_f3 = alu_or;
            F3_AND: alu_from_f3 = alu_and;
            default: alu_from_f3 = alu_add;
        endcase
    endfunction

    always_comb begin
        dec = '0;
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = funct3;
        dec.alu_op = alu_add;   // address adder for loads and stores
        legal = 1'b1;
        case (opcode)
            OP_LUI: begin
                dec.imm = imm_u;
                dec.use_imm = 1'b1;
                dec.alu_op = alu_pass_b;
                dec.wr_rd = 1'b1;
            end
            OP_AUIPC: begin
                dec.imm = imm_u;
                dec.use_imm = 1'b1;
                dec.use_pc = 1'b1;
                dec.wr_rd = 1'b1;
            end
            OP_JAL: begin
                dec.imm = imm_j;
                dec.is_jal = 1'b1;
                dec.wr_rd = 1'b1;
            end
            OP_JALR: begin
                dec.imm = imm_i;
                dec.is_jalr = 1'b1;
                dec.wr_rd = 1'b1;
                legal = funct3 == F3_JALR;
            end
            OP_BRANCH: begin
                dec.imm = imm_b;
                dec.is_branch = 1'b1;
                legal = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
            end
            OP_LOAD: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.wr_rd = 1'b1;
                legal = funct3 == F3_LW;
            end
            OP_STORE: begin
                dec.imm = imm_s;
                dec.use_imm = 1'b1;
                dec.is_store = 1'b1;
                legal = funct3 == F3_SW;
            end
            OP_OP_IMM: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.wr_rd = 1'b1;
                // only srai reads imm7 as a selector
                dec.alu_op = alu_from_f3(funct3, funct3 == F3_SR && imm7 == IMM7_ALT);
                if (funct3 == F3_SLL) begin
                    legal = imm7 == 7'h00;
                end else if (funct3 == F3_SR) begin
                    legal = imm7 == 7'h00 || imm7 == IMM7_ALT;
                end
            end
            OP_OP: begin
                dec.wr_rd = 1'b1;
                dec.alu_op = alu_from_f3(funct3, imm7 == IMM7_ALT);
                legal = imm7 == 7'h00 ||
                    (imm7 == IMM7_ALT && funct3 inside {F3_ADD_SUB, F3_SR});
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin   // retires as a no-op
            dec.illegal = 1'b1;
            dec.wr_rd = 1'b0;
            dec.is_load = 1'b0;
            dec.is_store = 1'b0;
            dec.is_branch = 1'b0;
            dec.is_jal = 1'b0;
            dec.is_jalr = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import rv32i_pkg::*; (
    input wire alu_op_e op,
    input wire word_t a,
    input wire word_t b,
    output word_t result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // low five bits only

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_sll: result = a << shamt;
            alu_slt: result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_xor: result = a ^ b;
            alu_srl: result = a >> shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            alu_or: result = a | b;
            alu_and: result = a & b;
            alu_pass_b: result = b;   // lui
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file import rv32i_pkg::*; (
    input wire clock,
    input wire reset,
    input wire reg_idx_t rs1,
    input wire reg_idx_t rs2,
    input wire reg_idx_t wr_idx,
    input wire logic wr_en,
    input wire word_t wr_data,
    output word_t rs1_data,
    output word_t rs2_data
);

    word_t regs [0:REG_COUNT-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // core gates x0 destinations before they reach the port
    a_no_x0_write: assert property (
        @(posedge clock) disable iff (reset) wr_en |-> wr_idx != '0
    ) else $error("register write enabled for x0");

endmodule

`default_nettype wire

/* src/program_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module program_counter import rv32i_pkg::*; (
    input wire clock,
    input wire reset,
    input wire decoded_t dec,
    input wire word_t rs1_data,
    input wire word_t rs2_data,
    input wire logic hold,
    input wire logic booting,
    output word_t pc,
    output word_t pc_next
);

    logic taken;
    word_t pc_plus_4;
    word_t rel_target;
    word_t jalr_sum;

    assign pc_plus_4 = pc + word_t'(4);
    assign rel_target = pc + dec.imm;   // jal and branches
    assign jalr_sum = rs1_data + dec.imm;

    always_comb begin
        case (dec.funct3)
            F3_BEQ: taken = rs1_data == rs2_data;
            F3_BNE: taken = rs1_data != rs2_data;
            F3_BLT: taken = $signed(rs1_data) < $signed(rs2_data);
            F3_BGE: taken = $signed(rs1_data) >= $signed(rs2_data);
            F3_BLTU: taken = rs1_data < rs2_data;
            F3_BGEU: taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (booting) begin
            pc_next = RESET_PC;
        end else if (hold) begin
            pc_next = pc;   // refetch stalled instr
        end else if (dec.is_jalr) begin
            pc_next = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (dec.is_jal || (dec.is_branch && taken)) begin
            pc_next = rel_target;
        end else begin
            pc_next = pc_plus_4;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset) pc_next[1:0] == 2'b00
    ) else $error("pc_next not word aligned: %h", pc_next);

endmodule

`default_nettype wire

/* src/core_control.sv */
`timescale 1ns/1ns
`default_nettype none

module core_control import rv32i_pkg::*; (
    input wire clock,
    input wire reset,
    input wire decoded_t dec,
    output ctrl_state_e state,
    output logic retire,
    output logic load_wb_en,
    output reg_idx_t load_rd
);

    ctrl_state_e state_next;
    logic uses_load_rd;
    logic port_busy;
    logic hazard;
    logic starts_load;

    assign load_wb_en = state == st_load_wb;

    assign uses_load_rd = dec.rd == load_rd || dec.rs1 == load_rd || dec.rs2 == load_rd;
    // load data owns the write port this cycle
    assign port_busy = dec.wr_rd && !dec.is_load && dec.rd != '0;
    assign hazard = load_wb_en && (uses_load_rd || port_busy);

    assign retire = state != st_boot && !hazard;
    assign starts_load = retire && dec.is_load && dec.rd != '0;

    always_comb begin
        case (state)
            st_boot: state_next = st_run;
            st_run: state_next = starts_load ? st_load_wb : st_run;
            // a hazard leaves after the bubble while the load is written
            st_load_wb: state_next = starts_load ? st_load_wb : st_run;
            default: state_next = st_boot;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_boot;
            load_rd <= '0;
        end else begin
            state <= state_next;
            if (starts_load) begin
                load_rd <= dec.rd;
            end
        end
    end

    // stalled instruction comes back unchanged and retires next cycle
    a_bubble_once: assert property (
        @(posedge clock) disable iff (reset)
        (load_wb_en && !retire) |=> (retire && $stable(dec))
    ) else $error("stalled instruction not retired unchanged after one bubble");

endmodule

`default_nettype wire

/* src/rv32i_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32i_core import rv32i_pkg::*; (
    input wire clock,
    input wire reset,
    input wire instr_t pm_data,
    input wire word_t dm_rdata,
    output word_t pm_address,
    output word_t dm_address,
    output word_t dm_wdata,
    output logic dm_write,
    output logic dm_read,
    output logic illegal_instr
);

    decoded_t dec;
    ctrl_state_e state;
    logic retire;
    logic load_wb_en;
    reg_idx_t load_rd;
    logic hold;
    logic booting;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t pc;
    word_t pc_next;
    word_t link;
    reg_idx_t wr_idx;
    logic wr_en;
    word_t wr_data;

    instr_decoder instr_decoder_inst (.instr(pm_data), .dec(dec));

    core_control core_control_inst (
        .clock(clock), .reset(reset), .dec(dec), .state(state),
        .retire(retire), .load_wb_en(load_wb_en), .load_rd(load_rd)
    );

    register_file register_file_inst (
        .clock(clock), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2),
        .wr_idx(wr_idx), .wr_en(wr_en), .wr_data(wr_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_a = dec.use_pc ? pc : rs1_data;
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    alu alu_inst (.op(dec.alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

    assign hold = !retire;
    assign booting = state == st_boot;

    program_counter program_counter_inst (
        .clock(clock), .reset(reset), .dec(dec), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .hold(hold), .booting(booting),
        .pc(pc), .pc_next(pc_next)
    );

    assign pm_address = pc_next;
    assign dm_address = alu_result;   // rs1 + imm
    assign dm_wdata = rs2_data;
    assign dm_write = retire && dec.is_store;
    assign dm_read = retire && dec.is_load;
    assign illegal_instr = retire && dec.illegal;

    assign link = pc + word_t'(4);

    always_comb begin
        if (load_wb_en) begin
            wr_idx = load_rd;
            wr_data = dm_rdata;
            wr_en = 1'b1;
        end else begin
            wr_idx = dec.rd;
            wr_data = (dec.is_jal || dec.is_jalr) ? link : alu_result;
            wr_en = retire && dec.wr_rd && !dec.is_load && dec.rd != '0;
        end
    end

    a_one_strobe: assert property (
        @(posedge clock) disable iff (reset) !(dm_write && dm_read)
    ) else $error("dm_write and dm_read high together");

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker import rv32i_pkg::*; (
    input wire clock,
    input wire reset,
    input wire instr_t prog [0:255],
    input wire word_t pm_address,
    input wire word_t dm_address,
    input wire word_t dm_wdata,
    input wire logic dm_write,
    input wire logic dm_read,
    input wire logic illegal_instr,
    output int value_errors,
    output int other_errors,
    output logic done
);

    localparam int EV_NONE = 0;
    localparam int EV_STORE = 1;
    localparam int EV_LOAD = 2;
    localparam int EV_ILLEGAL = 3;
    localparam word_t TAIL_FIRST_PC = 32'd864;   // word 216
    localparam word_t TAIL_LAST_PC = 32'd988;    // sw x31

    word_t m_pc;
    word_t m_regs [0:31];
    word_t m_mem [0:63];
    int ev_kind;
    word_t ev_addr;
    word_t ev_data;
    word_t ev_pc;

    function automatic word_t fill_word(input int idx);
        return word_t'(idx) * 32'h9e37_79b1 ^ 32'h0bad_f00d;
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'd0, $signed(x) < $signed(y)};
            3'd3: return {31'd0, x < y};
            3'd4: return x ^ y;
            3'd5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // runs one instruction of the reference model and sets ev_* for memory and illegal events
    function automatic void execute_one();
        instr_t ins;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rd;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        word_t res;
        word_t nxt;
        logic wr;
        logic tk;
        ins = prog[m_pc[9:2]];
        opc = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        rd = ins[11:7];
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt = m_pc + 32'd4;
        res = '0;
        wr = 1'b0;
        tk = 1'b0;
        ev_kind = EV_NONE;
        ev_pc = m_pc;
        ev_addr = '0;
        ev_data = '0;
        case (opc)
            OP_LUI: begin
                res = {ins[31:12], 12'h000};
                wr = 1'b1;
            end
            OP_AUIPC: begin
                res = m_pc + {ins[31:12], 12'h000};
                wr = 1'b1;
            end
            OP_JAL: begin
                res = m_pc + 32'd4;
                wr = 1'b1;
                nxt = m_pc + imm_j;
            end
            OP_JALR: begin
                if (f3 == 3'd0) begin
                    res = m_pc + 32'd4;
                    wr = 1'b1;
                    nxt = (a + imm_i) & ~32'd1;
                end else begin
                    ev_kind = EV_ILLEGAL;
                end
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0: tk = a == b;
                    3'd1: tk = a != b;
                    3'd4: tk = $signed(a) < $signed(b);
                    3'd5: tk = $signed(a) >= $signed(b);
                    3'd6: tk = a < b;
                    3'd7: tk = a >= b;
                    default: ev_kind = EV_ILLEGAL;
                endcase
                if (tk) begin
                    nxt = m_pc + imm_b;
                end
            end
            OP_LOAD: begin
                if (f3 == 3'd2) begin
                    ev_kind = EV_LOAD;
                    ev_addr = a + imm_i;
                    res = m_mem[ev_addr[7:2]];
                    wr = 1'b1;
                end else begin
                    ev_kind = EV_ILLEGAL;
                end
            end
            OP_STORE: begin
                if (f3 == 3'd2) begin
                    ev_kind = EV_STORE;
                    ev_addr = a + imm_s;
                    ev_data = b;
                    m_mem[ev_addr[7:2]] = b;
                end else begin
                    ev_kind = EV_ILLEGAL;
                end
            end
            OP_OP_IMM: begin
                if ((f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    ev_kind = EV_ILLEGAL;
                end else begin
                    res = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
                    wr = 1'b1;
                end
            end
            OP_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    res = alu_ref(f3, f7 == 7'h20, a, b);
                    wr = 1'b1;
                end else begin
                    ev_kind = EV_ILLEGAL;
                end
            end
            default: ev_kind = EV_ILLEGAL;
        endcase
        if (wr && rd != 5'd0) begin   // x0 stays zero
            m_regs[rd] = res;
        end
        m_pc = nxt;
    endfunction

    task automatic report_value(input string name, input word_t exp, input word_t act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        value_errors++;
    endtask

    task automatic compare_event();
        int kind;
        int steps;
        string name;
        kind = dm_write ? EV_STORE : (dm_read ? EV_LOAD : EV_ILLEGAL);
        steps = 0;
        ev_kind = EV_NONE;
        while (ev_kind == EV_NONE && steps < 2048) begin
            execute_one();
            steps++;
        end
        if (ev_kind == EV_NONE) begin
            $display("DUT event at %0t has no matching event in the model", $time);
            other_errors++;
        end else if (ev_kind != kind) begin
            $display("DUT event kind %0d at %0t, the model expects kind %0d from pc %h",
                     kind, $time, ev_kind, ev_pc);
            other_errors++;
        end else begin
            if (ev_pc >= TAIL_FIRST_PC) begin
                name = $sformatf("tail_store_x%0d", (ev_pc - TAIL_FIRST_PC) >> 2);
            end else if (kind == EV_ILLEGAL) begin
                name = $sformatf("illegal_pc_%h", ev_pc);
            end else begin
                name = $sformatf("%s_pc_%h", kind == EV_STORE ? "store" : "load", ev_pc);
            end
            if (pm_address != m_pc) begin   // fetch after the event
                report_value({name, "_next_pc"}, m_pc, pm_address);
            end
            if (kind != EV_ILLEGAL && dm_address != ev_addr) begin
                report_value({name, "_address"}, ev_addr, dm_address);
            end
            if (kind == EV_STORE && dm_wdata != ev_data) begin
                report_value({name, "_data"}, ev_data, dm_wdata);
            end
            if (kind == EV_STORE && ev_pc == TAIL_LAST_PC) begin
                done <= 1'b1;
            end
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            m_pc = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                m_mem[i] = fill_word(i);
            end
            value_errors = 0;
            other_errors = 0;
            done <= 1'b0;
        end else if (dm_write || dm_read || illegal_instr) begin
            compare_event();
        end
    end

endmodule

`default_nettype wire

/* tb/tb_rv32i.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i import rv32i_pkg::*; ();

    localparam int TAIL_START = 216;   // word index of the register dump
    localparam int MAX_CYCLES = 700;

    logic clock;
    logic reset;
    instr_t pm_data;
    word_t dm_rdata;
    word_t pm_address;
    word_t dm_address;
    word_t dm_wdata;
    logic dm_write;
    logic dm_read;
    logic illegal_instr;
    instr_t prog [0:255];
    word_t dmem [0:63];
    integer seed;
    int value_errors;
    int other_errors;
    int cycles;
    logic done;
    logic timed_out;

    rv32i_core rv32i_core_inst (
        .clock(clock), .reset(reset), .pm_data(pm_data), .dm_rdata(dm_rdata),
        .pm_address(pm_address), .dm_address(dm_address), .dm_wdata(dm_wdata),
        .dm_write(dm_write), .dm_read(dm_read), .illegal_instr(illegal_instr)
    );

    tb_checker tb_checker_inst (
        .clock(clock), .reset(reset), .prog(prog), .pm_address(pm_address),
        .dm_address(dm_address), .dm_wdata(dm_wdata), .dm_write(dm_write),
        .dm_read(dm_read), .illegal_instr(illegal_instr), .value_errors(value_errors),
        .other_errors(other_errors), .done(done)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    // both memories answer one cycle after the address
    always @(posedge clock) begin
        pm_data <= prog[pm_address[9:2]];
        if (dm_write) begin
            dmem[dm_address[7:2]] <= dm_wdata;
        end
        if (dm_read) begin
            dm_rdata <= dmem[dm_address[7:2]];
        end
    end

    function automatic int rnd(input int n);
        word_t r;
        r = $random(seed);
        return int'(r % word_t'(n));
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, F3_SW, imm[4:0], OP_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic build_program();
        int i;
        int kind;
        int k;
        logic [4:0] rd;
        logic [4:0] r1;
        logic [4:0] r2;
        logic [2:0] f3;
        logic [11:0] imm;
        word_t w;
        for (int j = 0; j < 256; j++) begin
            prog[j] = '0;
        end
        i = 0;
        while (i < TAIL_START) begin
            kind = rnd(21);
            rd = 5'(rnd(32));
            r1 = 5'(rnd(32));
            r2 = 5'(rnd(32));
            f3 = 3'(rnd(8));
            imm = 12'(rnd(4096));
            if (kind == 19 && i > TAIL_START - 3) begin
                kind = 0;   // no room for the jalr pair
            end
            if (kind <= 6) begin
                if (f3 == F3_SLL) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == F3_SR) begin
                    imm[11:5] = rnd(2) == 1 ? IMM7_ALT : 7'h00;
                end
                prog[i] = enc_i(imm, r1, f3, rd, OP_OP_IMM);
            end else if (kind <= 10) begin
                prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? IMM7_ALT : 7'h00,
                           r2, r1, f3, rd, OP_OP};
            end else if (kind <= 12) begin
                prog[i] = {20'(rnd(1048576)), rd, kind == 11 ? OP_LUI : OP_AUIPC};
            end else if (kind <= 14) begin
                prog[i] = enc_i({4'd0, 6'(rnd(64)), 2'b00}, 5'd0, F3_LW, rd, OP_LOAD);
            end else if (kind <= 16) begin
                prog[i] = enc_s({4'd0, 6'(rnd(64)), 2'b00}, r2);
            end else if (kind <= 18) begin
                k = 1 + rnd(8);
                if (i + k > TAIL_START) begin
                    k = TAIL_START - i;   // never past the tail
                end
                if (kind == 18) begin
                    prog[i] = enc_j(21'(k * 4), rd);
                end else begin
                    k = rnd(6);
                    f3 = k >= 2 ? 3'(k + 2) : 3'(k);
                    prog[i] = enc_b(13'((TAIL_START - i < 9 ? TAIL_START - i : 1 + rnd(8)) * 4),
                                    r2, r1, f3);
                end
            end else if (kind == 19) begin
                k = i + 2 + rnd(4);
                if (k > TAIL_START) begin
                    k = TAIL_START;
                end
                r1 = 5'(1 + rnd(31));
                prog[i] = enc_i(12'(k * 4), 5'd0, F3_ADD_SUB, r1, OP_OP_IMM);
                i++;
                prog[i] = enc_i(12'd0, r1, F3_JALR, rd, OP_JALR);
            end else begin
                w = $random(seed);
                prog[i] = {w[31:7], 7'b000_1111};   // unsupported fence opcode
            end
            i++;
        end
        for (int j = 0; j < 32; j++) begin
            prog[TAIL_START + j] = enc_s(12'(j * 4), 5'(j));   // dump x0..x31
        end
        prog[TAIL_START + 32] = enc_j(21'd0, 5'd0);
    endtask

    initial begin
        seed = 32'hedca;
        reset = 1'b1;
        pm_data = '0;
        dm_rdata = '0;
        timed_out = 1'b0;
        cycles = 0;
        build_program();
        for (int j = 0; j < 64; j++) begin
            dmem[j] = tb_checker_inst.fill_word(j);
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        while (done !== 1'b1 && cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: the tail stores did not finish within %0d cycles", MAX_CYCLES);
        end
        @(posedge clock);
        $display("errors: value %0d, other %0d, timeout %0d",
                 value_errors, other_errors, timed_out ? 1 : 0);
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/rv32i_pkg.sv
src/instr_decoder.sv
src/alu.sv
src/register_file.sv
src/program_counter.sv
src/core_control.sv
src/rv32i_core.sv
tb/tb_checker.sv
tb/tb_rv32i.sv

/* run.sh */
#!/bin/sh
# build and run the rv32i testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_rv32i -o tb_rv32i_sim \
    > build.log 2>&1 &&
./obj_dir/tb_rv32i_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
